//--- stepper_config.svh
`ifndef STEPPER_CONFIG_SVH
`define STEPPER_CONFIG_SVH

// microsteps in one quarter of the electrical period.
`define STEPPER_USTEPS 16

// index bits that select a table entry inside a quarter.
`define STEPPER_ANGLE_W 4

// coil current magnitude, full scale is 4095.
`define STEPPER_CUR_W 12

`define STEPPER_TIMER_W 10 // blank, on and off timers.

// cycles with both switches of a leg off when it changes side.
`define STEPPER_DEADTIME 4

`endif

//--- stepper_pkg.sv
`include "stepper_config.svh"

package stepper_pkg;

    // the same register is stepped as a count and decoded as a phase.
    typedef union packed {
        logic [7:0] count;
        struct packed {
            logic [1:0] quadrant;
            logic [5:0] angle; // only the low STEPPER_ANGLE_W bits select an entry.
        } phase;
    } ustep_pos_t;

    typedef struct packed {
        logic [`STEPPER_CUR_W-1:0] magnitude;
        logic                      polarity; // 1 drives the coil in the positive sense.
    } coil_target_t;

    // first quarter of a sine, scaled to 4095 at ninety degrees.
    localparam logic [`STEPPER_CUR_W-1:0] current_table [0:`STEPPER_USTEPS] = '{
        0,    401,  799,  1189, 1567, 1930, 2275, 2598,
        2896, 3165, 3405, 3611, 3783, 3919, 4016, 4075,
        4095
    };

endpackage

//--- bridge_pkg.sv
package bridge_pkg;

    // what one half bridge is asked to do.
    typedef enum logic [1:0] {
        leg_off  = 2'd0,
        leg_high = 2'd1,
        leg_low  = 2'd2
    } leg_state_t;

    // chopper cycle of one coil.
    typedef enum logic [1:0] {
        phase_idle  = 2'd0,
        phase_blank = 2'd1, // conducting, comparator ignored.
        phase_on    = 2'd2,
        phase_decay = 2'd3  // both low sides on, current recirculates.
    } chop_phase_t;

endpackage

//--- coil_drive_if.sv
`timescale 1ns/10ps

interface coil_drive_if;
    import bridge_pkg::*;

    leg_state_t  leg1;
    leg_state_t  leg2;
    chop_phase_t phase;

    modport source (
        output leg1, leg2, phase
    );

    modport sink (
        input leg1, leg2, phase
    );

endinterface

//--- microstep_indexer.sv
`timescale 1ns/10ps
`include "stepper_config.svh"

module microstep_indexer (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      step,
    input  logic                      dir,
    output stepper_pkg::coil_target_t target_a,
    output stepper_pkg::coil_target_t target_b
);
    import stepper_pkg::*;

    localparam int idx_w = `STEPPER_ANGLE_W + 1;
    localparam logic [idx_w-1:0] quarter = idx_w'(`STEPPER_USTEPS);

    logic             step_q;
    logic             step_rise;
    logic             dir_q;
    ustep_pos_t       pos;
    logic [1:0]       quadrant;
    logic [idx_w-1:0] angle;
    logic [idx_w-1:0] idx_a;
    logic [idx_w-1:0] idx_b;

    // the edge is registered so dir and step are taken on the same clock.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            step_q    <= 1'b0;
            step_rise <= 1'b0;
            dir_q     <= 1'b0;
            pos.count <= '0;
        end else begin
            step_q    <= step;
            step_rise <= step & ~step_q;
            dir_q     <= dir;
            if (step_rise) begin
                pos.count <= dir_q ? pos.count + 8'd1 : pos.count - 8'd1;
            end
        end
    end

    assign quadrant = pos.phase.quadrant;
    assign angle    = {1'b0, pos.phase.angle[`STEPPER_ANGLE_W-1:0]};
    assign idx_a    = quadrant[0] ? quarter - angle : angle; // odd quadrants run backwards.
    assign idx_b    = quarter - idx_a;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            target_a <= '{magnitude: current_table[0], polarity: 1'b1};
            target_b <= '{magnitude: current_table[`STEPPER_USTEPS], polarity: 1'b1};
        end else begin
            target_a <= '{magnitude: current_table[idx_a], polarity: ~quadrant[1]};
            target_b <= '{magnitude: current_table[idx_b],
                          polarity: ~(quadrant[1] ^ quadrant[0])};
        end
    end

endmodule

//--- coil_chopper.sv
`timescale 1ns/10ps
`include "stepper_config.svh"

module coil_chopper (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        enable,
    input  logic                        cmp,
    input  stepper_pkg::coil_target_t   target,
    input  logic [`STEPPER_TIMER_W-1:0] off_time,
    input  logic [`STEPPER_TIMER_W-1:0] blank_time,
    input  logic [`STEPPER_TIMER_W-1:0] min_on_time,
    coil_drive_if.source                drive
);
    import bridge_pkg::*;

    chop_phase_t                 phase;
    logic [`STEPPER_TIMER_W-1:0] timer;
    logic [`STEPPER_TIMER_W-1:0] on_cnt; // cycles conducting, current one included.
    logic                        conducting;
    leg_state_t                  drive_side;
    leg_state_t                  return_side;

    // a length of zero still gives one cycle.
    function automatic logic [`STEPPER_TIMER_W-1:0] last_tick(
        input logic [`STEPPER_TIMER_W-1:0] len
    );
        return (len == '0) ? '0 : len - 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (!resetn || !enable) begin
            phase  <= phase_idle;
            timer  <= '0;
            on_cnt <= '0;
        end else begin
            case (phase)
                phase_idle: begin
                    phase  <= phase_blank;
                    timer  <= last_tick(blank_time);
                    on_cnt <= 1;
                end
                phase_blank: begin
                    if (on_cnt != '1) on_cnt <= on_cnt + 1'b1;
                    if (timer == '0) begin
                        phase <= phase_on;
                    end else begin
                        timer <= timer - 1'b1;
                    end
                end
                phase_on: begin
                    // the comparator only ends the pulse once the minimum on time is served.
                    if (cmp && on_cnt >= min_on_time) begin
                        phase <= phase_decay;
                        timer <= last_tick(off_time);
                    end else if (on_cnt != '1) begin
                        on_cnt <= on_cnt + 1'b1;
                    end
                end
                default: begin
                    if (timer == '0) begin
                        phase  <= phase_blank;
                        timer  <= last_tick(blank_time);
                        on_cnt <= 1;
                    end else begin
                        timer <= timer - 1'b1;
                    end
                end
            endcase
        end
    end

    assign conducting  = (phase == phase_blank) || (phase == phase_on);
    assign drive_side  = target.polarity ? leg_high : leg_low;
    assign return_side = target.polarity ? leg_low : leg_high;

    // slow decay keeps both legs on the low side.
    assign drive.leg1  = conducting ? drive_side :
                         (phase == phase_decay) ? leg_low : leg_off;
    assign drive.leg2  = conducting ? return_side :
                         (phase == phase_decay) ? leg_low : leg_off;
    assign drive.phase = phase;

endmodule

//--- bridge_output_stage.sv
`timescale 1ns/10ps
`include "stepper_config.svh"

module bridge_output_stage (
    input  logic        clk,
    input  logic        resetn,
    input  logic        enable,
    input  logic        invert_high,
    input  logic        invert_low,
    input  logic [7:0]  cp_period,
    coil_drive_if.sink  coil_a,
    coil_drive_if.sink  coil_b,
    output logic [3:0]  s_h, // bit 0 is a1, then a2, b1, b2.
    output logic [3:0]  s_l,
    output logic        chargepump
);
    import bridge_pkg::*;

    localparam int dead_w = $clog2(`STEPPER_DEADTIME + 1);
    localparam logic [dead_w-1:0] dead_load = dead_w'(`STEPPER_DEADTIME - 1);

    leg_state_t        req [4];
    leg_state_t        side [4];      // last side that conducted.
    leg_state_t        side_next [4];
    logic [dead_w-1:0] dead [4];
    logic [dead_w-1:0] dead_next [4];
    logic [3:0]        gate_h;
    logic [3:0]        gate_l;
    logic [7:0]        cp_cnt;

    assign req[0] = coil_a.leg1;
    assign req[1] = coil_a.leg2;
    assign req[2] = coil_b.leg1;
    assign req[3] = coil_b.leg2;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            side_next[i] = side[i];
            dead_next[i] = '0;
            gate_h[i]    = 1'b0;
            gate_l[i]    = 1'b0;
            if (dead[i] != '0) begin
                dead_next[i] = dead[i] - 1'b1;
            end else if (req[i] != leg_off) begin
                side_next[i] = req[i];
                if (side[i] != leg_off && side[i] != req[i]) begin
                    dead_next[i] = dead_load; // this cycle is the first of the dead time.
                end else begin
                    gate_h[i] = (req[i] == leg_high);
                    gate_l[i] = (req[i] == leg_low);
                end
            end
        end
    end

    // disabling drops every gate on the next edge.
    always_ff @(posedge clk) begin
        if (!resetn || !enable) begin
            s_h <= {4{invert_high}};
            s_l <= {4{invert_low}};
            for (int i = 0; i < 4; i++) begin
                side[i] <= leg_off;
                dead[i] <= '0;
            end
        end else begin
            s_h  <= gate_h ^ {4{invert_high}};
            s_l  <= gate_l ^ {4{invert_low}};
            side <= side_next;
            dead <= dead_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn || !enable) begin
            cp_cnt     <= '0;
            chargepump <= 1'b0;
        end else if (cp_cnt == cp_period) begin
            cp_cnt     <= '0;
            chargepump <= ~chargepump;
        end else begin
            cp_cnt <= cp_cnt + 8'd1;
        end
    end

endmodule

//--- microstepper_top.sv
`timescale 1ns/10ps
`include "stepper_config.svh"

module microstepper_top (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        step,
    input  logic                        dir,
    input  logic                        enable,
    input  logic                        cmp_a,
    input  logic                        cmp_b,
    input  logic [`STEPPER_TIMER_W-1:0] off_time,
    input  logic [`STEPPER_TIMER_W-1:0] blank_time,
    input  logic [`STEPPER_TIMER_W-1:0] min_on_time,
    input  logic [7:0]                  cp_period,
    input  logic                        invert_high,
    input  logic                        invert_low,
    output logic [3:0]                  s_h,
    output logic [3:0]                  s_l,
    output logic [`STEPPER_CUR_W-1:0]   target_a,
    output logic [`STEPPER_CUR_W-1:0]   target_b,
    output logic                        chargepump
);
    import stepper_pkg::*;

    coil_target_t tgt_a;
    coil_target_t tgt_b;

    coil_drive_if coil_a ();
    coil_drive_if coil_b ();

    microstep_indexer indexer (
        .clk      (clk),
        .resetn   (resetn),
        .step     (step),
        .dir      (dir),
        .target_a (tgt_a),
        .target_b (tgt_b)
    );

    coil_chopper chop_a (
        .clk         (clk),
        .resetn      (resetn),
        .enable      (enable),
        .cmp         (cmp_a),
        .target      (tgt_a),
        .off_time    (off_time),
        .blank_time  (blank_time),
        .min_on_time (min_on_time),
        .drive       (coil_a)
    );

    coil_chopper chop_b (
        .clk         (clk),
        .resetn      (resetn),
        .enable      (enable),
        .cmp         (cmp_b),
        .target      (tgt_b),
        .off_time    (off_time),
        .blank_time  (blank_time),
        .min_on_time (min_on_time),
        .drive       (coil_b)
    );

    bridge_output_stage bridge (
        .clk         (clk),
        .resetn      (resetn),
        .enable      (enable),
        .invert_high (invert_high),
        .invert_low  (invert_low),
        .cp_period   (cp_period),
        .coil_a      (coil_a),
        .coil_b      (coil_b),
        .s_h         (s_h),
        .s_l         (s_l),
        .chargepump  (chargepump)
    );

    // the reference DAC outside takes only the magnitudes.
    assign target_a = tgt_a.magnitude;
    assign target_b = tgt_b.magnitude;

endmodule

//--- microstepper_assert.sv
`timescale 1ns/10ps
`include "stepper_config.svh"

module microstepper_assert (
    input logic                        clk,
    input logic                        resetn,
    input logic                        enable,
    input logic                        invert_high,
    input logic                        invert_low,
    input logic [3:0]                  s_h,
    input logic [3:0]                  s_l,
    input logic [`STEPPER_TIMER_W-1:0] off_time,
    input bridge_pkg::chop_phase_t     phase_a,
    input bridge_pkg::chop_phase_t     phase_b
);
    import bridge_pkg::*;

    logic [`STEPPER_TIMER_W:0] run_a; // length of the current decay run.
    logic [`STEPPER_TIMER_W:0] run_b;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            run_a <= '0;
            run_b <= '0;
        end else begin
            run_a <= (phase_a == phase_decay) ? run_a + 1'b1 : '0;
            run_b <= (phase_b == phase_decay) ? run_b + 1'b1 : '0;
        end
    end

    // the pins were registered with the inversion of the previous cycle.
    assert property (@(posedge clk) disable iff (!resetn)
        ((s_h ^ {4{$past(invert_high)}}) & (s_l ^ {4{$past(invert_low)}})) == 4'b0)
        else $error("high and low switch of one leg are on together");

    assert property (@(posedge clk) disable iff (!resetn)
        (enable && $fell(phase_a == phase_decay)) |-> run_a == off_time)
        else $error("coil a decay length differs from off_time");

    assert property (@(posedge clk) disable iff (!resetn)
        (enable && $fell(phase_b == phase_decay)) |-> run_b == off_time)
        else $error("coil b decay length differs from off_time");

    assert property (@(posedge clk) disable iff (!resetn)
        $fell(enable) |=> (s_h == {4{$past(invert_high)}} && s_l == {4{$past(invert_low)}}))
        else $error("gates still on one cycle after enable fell");

endmodule

bind microstepper_top microstepper_assert assertions (
    .clk         (clk),
    .resetn      (resetn),
    .enable      (enable),
    .invert_high (invert_high),
    .invert_low  (invert_low),
    .s_h         (s_h),
    .s_l         (s_l),
    .off_time    (off_time),
    .phase_a     (coil_a.phase),
    .phase_b     (coil_b.phase)
);

//--- tb_microstepper.sv
`timescale 1ns/10ps
`include "stepper_config.svh"

module tb_microstepper;

    logic                        clk;
    logic                        resetn;
    logic                        step;
    logic                        dir;
    logic                        enable;
    logic                        cmp_a;
    logic                        cmp_b;
    logic [`STEPPER_TIMER_W-1:0] off_time;
    logic [`STEPPER_TIMER_W-1:0] blank_time;
    logic [`STEPPER_TIMER_W-1:0] min_on_time;
    logic [7:0]                  cp_period;
    logic                        invert_high;
    logic                        invert_low;
    logic [3:0]                  s_h;
    logic [3:0]                  s_l;
    logic [`STEPPER_CUR_W-1:0]   target_a;
    logic [`STEPPER_CUR_W-1:0]   target_b;
    logic                        chargepump;

    int    fd;
    int    code;
    string line;

    microstepper_top uut (
        .clk         (clk),
        .resetn      (resetn),
        .step        (step),
        .dir         (dir),
        .enable      (enable),
        .cmp_a       (cmp_a),
        .cmp_b       (cmp_b),
        .off_time    (off_time),
        .blank_time  (blank_time),
        .min_on_time (min_on_time),
        .cp_period   (cp_period),
        .invert_high (invert_high),
        .invert_low  (invert_low),
        .s_h         (s_h),
        .s_l         (s_l),
        .target_a    (target_a),
        .target_b    (target_b),
        .chargepump  (chargepump)
    );

    always #10 clk = ~clk;

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAIL at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
            $display("Verification failed");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    task automatic give_up(input string what);
        $display("Timeout at %0t ns: %s never came", $time, what);
        $display("Verification failed");
        $fatal(1, "timeout");
    endtask

    // one rising edge on step, held high for one cycle.
    task automatic pulse_step(input logic d);
        @(negedge clk);
        dir  = d;
        step = 1'b1;
        @(negedge clk);
        step = 1'b0;
        @(negedge clk);
        @(negedge clk); // targets moved on the second edge after the step.
    endtask

    task automatic wait_pattern(input logic [3:0] sh, input logic [3:0] sl);
        int n;
        bit seen;
        seen = 0;
        for (n = 0; n < 200 && !seen; n++) begin
            @(negedge clk);
            seen = (s_h === sh) && (s_l === sl);
        end
        if (!seen) give_up($sformatf("switch pattern %h/%h", sh, sl));
    endtask

    task automatic hold_pattern(input logic [3:0] sh, input logic [3:0] sl, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_value("s_h", s_h, sh);
            check_value("s_l", s_l, sl);
        end
    endtask

    task automatic wait_toggle(output int cycles);
        logic start;
        bit   seen;
        int   n;
        start  = chargepump;
        seen   = 0;
        cycles = 0;
        for (n = 0; n < 600 && !seen; n++) begin
            @(negedge clk);
            cycles = n + 1;
            seen   = (chargepump !== start);
        end
        if (!seen) give_up("charge pump toggle");
    endtask

    task automatic run_line(input string text);
        byte         op;
        logic [31:0] f0, f1, f2, f3, f4, f5;
        int          cycles;
        op = "#";
        void'($sscanf(text, "%c %h %h %h %h %h %h", op, f0, f1, f2, f3, f4, f5));
        case (op)
            "R": begin
                invert_high = f0[0];
                invert_low  = f1[0];
                resetn      = 1'b0;
                repeat (3) @(negedge clk);
                check_value("target_a after reset", target_a, f2);
                check_value("target_b after reset", target_b, f3);
                check_value("s_h after reset", s_h, f4);
                check_value("s_l after reset", s_l, f5);
                check_value("chargepump after reset", chargepump, 0);
                resetn = 1'b1;
            end
            "C": begin
                @(negedge clk);
                off_time    = f0[`STEPPER_TIMER_W-1:0];
                blank_time  = f1[`STEPPER_TIMER_W-1:0];
                min_on_time = f2[`STEPPER_TIMER_W-1:0];
                cp_period   = f3[7:0];
            end
            "I": begin
                @(negedge clk);
                invert_high = f0[0];
                invert_low  = f1[0];
            end
            "E": begin
                @(negedge clk);
                enable = f0[0];
            end
            "K": begin
                @(negedge clk);
                cmp_a = f0[0];
                cmp_b = f1[0];
            end
            "S": begin
                pulse_step(f0[0]);
                check_value("target_a", target_a, f1);
                check_value("target_b", target_b, f2);
            end
            "M": repeat (f1) pulse_step(f0[0]);
            "W": wait_pattern(f0[3:0], f1[3:0]);
            "H": hold_pattern(f0[3:0], f1[3:0], f2);
            "T": begin
                wait_toggle(cycles);
                wait_toggle(cycles);
                check_value("charge pump half period", cycles, f0);
            end
            "Q": repeat (f1) begin
                @(negedge clk);
                check_value("chargepump", chargepump, f0);
            end
            "#", " ", "\n", "\r": ;
            default: begin
                $display("unknown trace command in line: %s", text);
                $display("Verification failed");
                $fatal(1, "bad trace");
            end
        endcase
    endtask

    initial begin
        clk         = 1'b0;
        resetn      = 1'b0;
        step        = 1'b0;
        dir         = 1'b1;
        enable      = 1'b0;
        cmp_a       = 1'b0;
        cmp_b       = 1'b0;
        off_time    = '0;
        blank_time  = '0;
        min_on_time = '0;
        cp_period   = '0;
        invert_high = 1'b0;
        invert_low  = 1'b0;
        fd = $fopen("microstepper_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open microstepper_trace.txt");
            $display("Verification failed");
            $fatal(1, "no trace");
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0) run_line(line);
        end
        $fclose(fd);
        $display("Verification passed");
        $finish;
    end

endmodule

//--- microstepper_trace.txt
# op R: inv_h inv_l tgt_a tgt_b s_h s_l | C: off blank min_on cp | I: inv_h inv_l | E: enable
# op K: cmp_a cmp_b | S: dir tgt_a tgt_b | M: dir steps | W: s_h s_l | H: s_h s_l cycles | T: cycles | Q: level cycles
R 1 1 000 fff f f
C 00a 003 008 03
I 0 0
E 1
W 5 a
S 1 191 feb
M 1 3e
S 1 fff 000
H 1 2 4
H 9 6 1
M 1 3f
S 1 000 fff
H 8 4 4
H a 5 1
M 1 3f
S 1 fff 000
H 2 1 4
H 6 9 1
M 1 3f
S 1 000 fff
H 4 8 4
H 5 a 1
S 0 191 feb
H 4 8 4
H 6 9 1
S 1 000 fff
H 4 8 4
H 5 a 1
K 1 0
W 4 b
H 4 b 5
H 4 a 4
H 5 a 4
H 4 a 4
H 4 b 6
K 0 0
W 5 a
I 1 0
W a a
I 0 1
W 5 5
I 0 0
W 5 a
T 4
T 4
E 0
H 0 0 2
Q 0 a
C 00a 003 008 05
E 1
T 6

//--- src.f
+incdir+.
stepper_pkg.sv
bridge_pkg.sv
coil_drive_if.sv
microstep_indexer.sv
coil_chopper.sv
bridge_output_stage.sv
microstepper_top.sv
microstepper_assert.sv
tb_microstepper.sv

//--- Bender.yml
package:
  name: microstepper

sources:
  - include_dirs:
      - .
    files:
      - stepper_pkg.sv
      - bridge_pkg.sv
      - coil_drive_if.sv
      - microstep_indexer.sv
      - coil_chopper.sv
      - bridge_output_stage.sv
      - microstepper_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - microstepper_assert.sv
      - tb_microstepper.sv
